/* Makefile */
TOP := fetch_frontend_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f fetch_frontend.f \
		-Mdir obj_dir -o sim
	@out="$$(./obj_dir/sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf obj_dir

/* fetch_frontend.f */
hw/fetch_pkg.sv
hw/fetch_pc_stage.sv
hw/branch_target_buffer.sv
hw/icache_line.sv
hw/fetch_predecode.sv
hw/instr_buffer.sv
hw/fetch_frontend.sv
tb/tb_clock.sv
tb/fetch_frontend_tb.sv

/* hw/branch_target_buffer.sv */
`timescale 1ns/1ps

module branch_target_buffer (
    input  logic        clk,
    input  logic        rstn,
    input  logic [31:0] pc_if1,
    input  logic        ex_br,
    input  logic [31:0] ex_br_pc,
    input  logic [31:0] ex_br_target,
    output logic [31:0] pc_predict
);

    ////////////////////////////////////////
    // Storage
    ////////////////////////////////////////

    logic [fetch_pkg::BTB_ENTRIES-1:0] btb_valid;
    logic [fetch_pkg::BTB_TAG_W-1:0]   btb_tag    [fetch_pkg::BTB_ENTRIES];
    logic [31:0]                       btb_target [fetch_pkg::BTB_ENTRIES];

    // Lookup side
    logic [fetch_pkg::BTB_IDX_W-1:0] rd_idx;
    logic [fetch_pkg::BTB_TAG_W-1:0] rd_tag;
    logic                            hit;

    // Training side
    logic [fetch_pkg::BTB_IDX_W-1:0] wr_idx;
    logic [fetch_pkg::BTB_TAG_W-1:0] wr_tag;

    // Word index bits, byte offset dropped
    assign rd_idx = pc_if1[fetch_pkg::BTB_IDX_W+1:2];
    assign rd_tag = pc_if1[31:fetch_pkg::BTB_IDX_W+2];

    assign wr_idx = ex_br_pc[fetch_pkg::BTB_IDX_W+1:2];
    assign wr_tag = ex_br_pc[31:fetch_pkg::BTB_IDX_W+2];

    ////////////////////////////////////////
    // Combinational prediction
    ////////////////////////////////////////

    assign hit = btb_valid[rd_idx] && (btb_tag[rd_idx] == rd_tag);

    // Taken target on a hit, else fall through
    assign pc_predict = hit ? btb_target[rd_idx] : pc_if1 + 32'd4;

    ////////////////////////////////////////
    // Training on execute redirects
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstn) begin
            btb_valid <= '0;
        end else if (ex_br) begin
            btb_valid[wr_idx] <= 1'b1;
        end
    end

    // Last redirect for this index wins
    always_ff @(posedge clk) begin
        if (ex_br) begin
            btb_tag[wr_idx]    <= wr_tag;
            btb_target[wr_idx] <= ex_br_target;
        end
    end

endmodule

/* hw/fetch_frontend.sv */
`timescale 1ns/1ps

module fetch_frontend (
    input  logic        clk,
    input  logic        rstn,
    input  logic        ex_br,
    input  logic [31:0] ex_br_pc,
    input  logic [31:0] ex_br_target,
    input  logic        ib_pop,
    output logic        ib_valid,
    output logic [31:0] ib_pc,
    output logic [31:0] ib_instr,
    output logic        mem_req,
    output logic [31:0] mem_addr,
    input  logic        mem_valid,
    input  logic [31:0] mem_rdata
);

    // IF1 side
    logic [31:0] pc_if1;
    logic [31:0] pc_predict;
    logic [31:0] instr_if1;
    logic        stall_icache;
    logic        fetch_valid;

    // IF2 side
    logic        if2_valid;
    logic [31:0] if2_pc;
    logic [31:0] if2_instr;
    logic        br_pd;
    logic [31:0] pc_pd;
    logic        ib_full;

    ////////////////////////////////////////
    // IF1
    ////////////////////////////////////////

    fetch_pc_stage u_pc_stage (
        .clk          (clk),
        .rstn         (rstn),
        .pc_predict   (pc_predict),
        .ex_br        (ex_br),
        .ex_br_target (ex_br_target),
        .br_pd        (br_pd),
        .pc_pd        (pc_pd),
        .stall_icache (stall_icache),
        .ib_full      (ib_full),
        .pc_if1       (pc_if1),
        .fetch_valid  (fetch_valid)
    );

    branch_target_buffer u_btb (
        .clk          (clk),
        .rstn         (rstn),
        .pc_if1       (pc_if1),
        .ex_br        (ex_br),
        .ex_br_pc     (ex_br_pc),
        .ex_br_target (ex_br_target),
        .pc_predict   (pc_predict)
    );

    icache_line u_icache (
        .clk          (clk),
        .rstn         (rstn),
        .pc_if1       (pc_if1),
        .instr_if1    (instr_if1),
        .stall_icache (stall_icache),
        .mem_req      (mem_req),
        .mem_addr     (mem_addr),
        .mem_valid    (mem_valid),
        .mem_rdata    (mem_rdata)
    );

    ////////////////////////////////////////
    // IF2 and buffer
    ////////////////////////////////////////

    fetch_predecode u_predecode (
        .clk         (clk),
        .rstn        (rstn),
        .fetch_valid (fetch_valid),
        .pc_if1      (pc_if1),
        .instr_if1   (instr_if1),
        .ib_full     (ib_full),
        .ex_br       (ex_br),
        .if2_valid   (if2_valid),
        .if2_pc      (if2_pc),
        .if2_instr   (if2_instr),
        .br_pd       (br_pd),
        .pc_pd       (pc_pd)
    );

    instr_buffer u_ibuf (
        .clk       (clk),
        .rstn      (rstn),
        .if2_valid (if2_valid),
        .if2_pc    (if2_pc),
        .if2_instr (if2_instr),
        .ex_br     (ex_br),
        .ib_pop    (ib_pop),
        .ib_full   (ib_full),
        .ib_valid  (ib_valid),
        .ib_pc     (ib_pc),
        .ib_instr  (ib_instr)
    );

endmodule

/* hw/fetch_pc_stage.sv */
`timescale 1ns/1ps

module fetch_pc_stage (
    input  logic        clk,
    input  logic        rstn,
    input  logic [31:0] pc_predict,
    input  logic        ex_br,
    input  logic [31:0] ex_br_target,
    input  logic        br_pd,
    input  logic [31:0] pc_pd,
    input  logic        stall_icache,
    input  logic        ib_full,
    output logic [31:0] pc_if1,
    output logic        fetch_valid
);

    logic        started;
    logic        stall;

    // Either stall source freezes IF1
    assign stall = stall_icache | ib_full;

    // High from the second cycle after reset release
    always_ff @(posedge clk) begin
        if (!rstn) begin
            started <= 1'b0;
        end else begin
            started <= 1'b1;
        end
    end

    // Kill the IF1 fetch on stalls and on a predecode jump
    assign fetch_valid = started & ~stall & ~br_pd;

    ////////////////////////////////////////
    // Next PC select
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstn) begin
            pc_if1 <= fetch_pkg::RESET_PC;
        end else if (ex_br) begin
            pc_if1 <= ex_br_target;
        end else if (br_pd) begin
            pc_if1 <= pc_pd;
        end else if (!stall) begin
            pc_if1 <= pc_predict;
        end
    end

    // Predecode keeps a jump in IF2 until the buffer has room
    a_no_pd_in_full: assert property (@(posedge clk) disable iff (!rstn)
        br_pd |-> !ib_full);

endmodule

/* hw/fetch_pkg.sv */
package fetch_pkg;

    ////////////////////////////////////////
    // Fetch address and buffer sizing
    ////////////////////////////////////////

    // First fetch address out of reset
    localparam logic [31:0] RESET_PC = 32'h1c00_0000;

    // Instruction buffer entries and pointer widths
    localparam int IB_DEPTH = 8;
    localparam int IB_PTR_W = $clog2(IB_DEPTH);
    localparam int IB_CNT_W = $clog2(IB_DEPTH + 1);

    // Direct-mapped predictor, index from PC[4:2]
    localparam int BTB_ENTRIES = 8;
    localparam int BTB_IDX_W   = $clog2(BTB_ENTRIES);
    localparam int BTB_TAG_W   = 32 - BTB_IDX_W - 2;

    // One cache line of 16 bytes
    localparam int LINE_WORDS = 4;
    localparam int LINE_OFF_W = $clog2(LINE_WORDS);
    localparam int LINE_TAG_W = 32 - LINE_OFF_W - 2;

    ////////////////////////////////////////
    // Opcodes and encodings
    ////////////////////////////////////////

    // Major opcodes of the direct jumps
    localparam logic [5:0] OP_B  = 6'b010100;
    localparam logic [5:0] OP_BL = 6'b010101;

    // Predecode classes
    typedef enum logic [1:0] {
        PD_NONE,
        PD_B,
        PD_BL
    } pd_op_e;

    // Cache fill FSM
    typedef enum logic {
        IC_IDLE,
        IC_FILL
    } ic_state_e;

endpackage

/* hw/fetch_predecode.sv */
`timescale 1ns/1ps

module fetch_predecode (
    input  logic        clk,
    input  logic        rstn,
    input  logic        fetch_valid,
    input  logic [31:0] pc_if1,
    input  logic [31:0] instr_if1,
    input  logic        ib_full,
    input  logic        ex_br,
    output logic        if2_valid,
    output logic [31:0] if2_pc,
    output logic [31:0] if2_instr,
    output logic        br_pd,
    output logic [31:0] pc_pd
);

    logic              if2_held;
    fetch_pkg::pd_op_e pd_op;
    logic [25:0]       offs26;
    logic [31:0]       jump_target;

    ////////////////////////////////////////
    // IF2 register
    ////////////////////////////////////////

    // Entry holds while the buffer is full
    always_ff @(posedge clk) begin
        if (!rstn) begin
            if2_held <= 1'b0;
        end else if (ex_br) begin
            if2_held <= 1'b0;
        end else if (!ib_full) begin
            if2_held <= fetch_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_valid && !ib_full) begin
            if2_pc    <= pc_if1;
            if2_instr <= instr_if1;
        end
    end

    // Write strobe into the buffer
    assign if2_valid = if2_held & ~ib_full;

    ////////////////////////////////////////
    // B / BL detection
    ////////////////////////////////////////

    always_comb begin
        case (if2_instr[31:26])
            fetch_pkg::OP_B:  pd_op = fetch_pkg::PD_B;
            fetch_pkg::OP_BL: pd_op = fetch_pkg::PD_BL;
            default:          pd_op = fetch_pkg::PD_NONE;
        endcase
    end

    // offs[15:0] in bits 25:10, offs[25:16] in bits 9:0
    assign offs26      = {if2_instr[9:0], if2_instr[25:10]};
    assign jump_target = if2_pc + {{4{offs26[25]}}, offs26, 2'b00};

    // Redirect only if IF1 did not already move to the target
    assign br_pd = if2_valid && (pd_op != fetch_pkg::PD_NONE) && (jump_target != pc_if1);
    assign pc_pd = jump_target;

endmodule

/* hw/icache_line.sv */
`timescale 1ns/1ps

module icache_line (
    input  logic        clk,
    input  logic        rstn,
    input  logic [31:0] pc_if1,
    output logic [31:0] instr_if1,
    output logic        stall_icache,
    output logic        mem_req,
    output logic [31:0] mem_addr,
    input  logic        mem_valid,
    input  logic [31:0] mem_rdata
);

    fetch_pkg::ic_state_e state;

    // Single line, tag and words
    logic                             line_valid;
    logic [fetch_pkg::LINE_TAG_W-1:0] line_tag;
    logic [31:0]                      line_data [fetch_pkg::LINE_WORDS];

    logic [fetch_pkg::LINE_OFF_W-1:0] fill_cnt;
    logic [fetch_pkg::LINE_TAG_W-1:0] pc_tag;
    logic [fetch_pkg::LINE_OFF_W-1:0] pc_word;
    logic                             hit;
    logic                             miss_start;
    logic                             last_word;

    ////////////////////////////////////////
    // Lookup
    ////////////////////////////////////////

    assign pc_tag  = pc_if1[31:fetch_pkg::LINE_OFF_W+2];
    assign pc_word = pc_if1[fetch_pkg::LINE_OFF_W+1:2];

    assign hit          = line_valid && (line_tag == pc_tag);
    assign instr_if1    = line_data[pc_word];
    assign stall_icache = ~hit;

    // Miss seen while idle opens a fill
    assign miss_start = (state == fetch_pkg::IC_IDLE) && !hit;
    assign last_word  = mem_valid && (int'(fill_cnt) == fetch_pkg::LINE_WORDS - 1);

    // Line-aligned fill address, held by the tag register
    assign mem_addr = {line_tag, {(fetch_pkg::LINE_OFF_W + 2){1'b0}}};

    ////////////////////////////////////////
    // Fill FSM
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state      <= fetch_pkg::IC_IDLE;
            line_valid <= 1'b0;
            mem_req    <= 1'b0;
            fill_cnt   <= '0;
        end else begin
            case (state)
                fetch_pkg::IC_IDLE: begin
                    if (!hit) begin
                        state      <= fetch_pkg::IC_FILL;
                        line_valid <= 1'b0;
                        mem_req    <= 1'b1;
                        fill_cnt   <= '0;
                    end
                end
                fetch_pkg::IC_FILL: begin
                    // Words come in ascending order
                    if (mem_valid) begin
                        fill_cnt <= fill_cnt + 1'b1;
                    end
                    if (last_word) begin
                        state      <= fetch_pkg::IC_IDLE;
                        mem_req    <= 1'b0;
                        line_valid <= 1'b1;
                    end
                end
                default: state <= fetch_pkg::IC_IDLE;
            endcase
        end
    end

    // Tag latched at miss, stays put for the whole fill
    always_ff @(posedge clk) begin
        if (miss_start) begin
            line_tag <= pc_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (state == fetch_pkg::IC_FILL && mem_valid) begin
            line_data[fill_cnt] <= mem_rdata;
        end
    end

    // Memory only answers an open request
    a_valid_needs_req: assert property (@(posedge clk) disable iff (!rstn)
        mem_valid |-> mem_req);

endmodule

/* hw/instr_buffer.sv */
`timescale 1ns/1ps

module instr_buffer (
    input  logic        clk,
    input  logic        rstn,
    input  logic        if2_valid,
    input  logic [31:0] if2_pc,
    input  logic [31:0] if2_instr,
    input  logic        ex_br,
    input  logic        ib_pop,
    output logic        ib_full,
    output logic        ib_valid,
    output logic [31:0] ib_pc,
    output logic [31:0] ib_instr
);

    // PC and instruction storage
    logic [31:0] buf_pc    [fetch_pkg::IB_DEPTH];
    logic [31:0] buf_instr [fetch_pkg::IB_DEPTH];

    logic [fetch_pkg::IB_PTR_W-1:0] wr_ptr;
    logic [fetch_pkg::IB_PTR_W-1:0] rd_ptr;
    logic [fetch_pkg::IB_CNT_W-1:0] count;
    logic                           do_push;
    logic                           do_pop;

    ////////////////////////////////////////
    // Status and head
    ////////////////////////////////////////

    assign ib_full  = (int'(count) == fetch_pkg::IB_DEPTH);
    assign ib_valid = (count != '0);

    // Head entry shown directly
    assign ib_pc    = buf_pc[rd_ptr];
    assign ib_instr = buf_instr[rd_ptr];

    assign do_push = if2_valid & ~ib_full;
    assign do_pop  = ib_pop & ib_valid;

    ////////////////////////////////////////
    // Pointers and count
    ////////////////////////////////////////

    // Pointers wrap naturally, depth is a power of two
    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (ex_br) begin
            // Redirect drops all wrong-path entries
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            buf_pc[wr_ptr]    <= if2_pc;
            buf_instr[wr_ptr] <= if2_instr;
        end
    end

    // Predecode must hold its entry while full
    a_no_write_full: assert property (@(posedge clk) disable iff (!rstn)
        if2_valid |-> !ib_full);

endmodule

/* tb/fetch_frontend_tb.sv */
`timescale 1ns/1ps

module fetch_frontend_tb;

    // Cycle budgets per test, worst case fill delays included
    localparam int BUDGET_SEQ    = 400;
    localparam int BUDGET_JUMP   = 800;
    localparam int BUDGET_FULL   = 900;
    localparam int BUDGET_FLUSH  = 600;
    localparam int BUDGET_BTB    = 700;
    localparam int BUDGET_RANDOM = 1200;
    localparam int WATCHDOG_NS   = (BUDGET_SEQ + BUDGET_JUMP + BUDGET_FULL + BUDGET_FLUSH
                                    + BUDGET_BTB + BUDGET_RANDOM) * 40 + 4000;
    // No pops for this long, buffer surely full
    localparam int HOLD_CYCLES = 80;

    logic        clk;
    logic        rstn;
    logic        ex_br;
    logic [31:0] ex_br_pc;
    logic [31:0] ex_br_target;
    logic        ib_pop;
    logic        ib_valid;
    logic [31:0] ib_pc;
    logic [31:0] ib_instr;
    logic        mem_req;
    logic [31:0] mem_addr;
    logic        mem_valid;
    logic [31:0] mem_rdata;

    // Program image, jump table, trained redirects
    logic [31:0]       prog    [logic [31:0]];
    logic [31:0]       jump_to [logic [31:0]];
    logic [31:0]       trained [logic [31:0]];

    logic [31:0] model_pc;
    logic [15:0] mem_lfsr;
    logic [15:0] pop_lfsr;
    int          err_count;
    int          test_err_base;
    int          pass_tests;
    int          fail_tests;

    tb_clock clkgen (
        .clk (clk)
    );

    fetch_frontend uut (
        .clk          (clk),
        .rstn         (rstn),
        .ex_br        (ex_br),
        .ex_br_pc     (ex_br_pc),
        .ex_br_target (ex_br_target),
        .ib_pop       (ib_pop),
        .ib_valid     (ib_valid),
        .ib_pc        (ib_pc),
        .ib_instr     (ib_instr),
        .mem_req      (mem_req),
        .mem_addr     (mem_addr),
        .mem_valid    (mem_valid),
        .mem_rdata    (mem_rdata)
    );

    ////////////////////////////////////////
    // Random bits and memory image
    ////////////////////////////////////////

    // 16-bit Galois LFSR, one step per bit
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    task automatic draw_bits(inout logic [15:0] st, input int n, output int val);
        int i;
        val = 0;
        for (i = 0; i < n; i++) begin
            val = (val << 1) | int'(st[0]);
            st = lfsr_next(st);
        end
    endtask

    function automatic logic [31:0] prog_addr(input int off);
        return fetch_pkg::RESET_PC + 32'(off);
    endfunction

    // Unwritten words: non-jump opcode, rest folded from the whole address
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        if (prog.exists(addr)) begin
            return prog[addr];
        end
        return {6'b000011, addr[27:2] ^ {22'h0, addr[31:28]}};
    endfunction

    // offs[15:0] in bits 25:10, offs[25:16] in bits 9:0
    task automatic place_jump(input logic [31:0] addr, input logic [5:0] opcode,
                              input logic [31:0] target);
        logic [31:0] diff;
        diff = target - addr;
        prog[addr]    = {opcode, diff[17:2], diff[27:18]};
        jump_to[addr] = target;
    endtask

    // B forward, BL backward, then B far ahead
    task automatic build_program();
        prog.delete();
        jump_to.delete();
        place_jump(prog_addr('h040), fetch_pkg::OP_B, prog_addr('h100));
        place_jump(prog_addr('h120), fetch_pkg::OP_BL, prog_addr('h080));
        place_jump(prog_addr('h09c), fetch_pkg::OP_B, prog_addr('h200));
    endtask

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    // Trained redirect first, then direct jump, else next word
    function automatic logic [31:0] model_next(input logic [31:0] pc);
        if (trained.exists(pc)) begin
            return trained[pc];
        end
        if (jump_to.exists(pc)) begin
            return jump_to[pc];
        end
        return pc + 32'd4;
    endfunction

    ////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////

    task automatic check_pc(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("ERROR at time %0t: %s is %h, expected %h", $time, what, got, exp);
            err_count++;
        end
    endtask

    task automatic check_instr(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("ERROR at time %0t: %s is %h, expected %h", $time, what, got, exp);
            err_count++;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("ERROR at time %0t: %s is %b, expected %b", $time, what, got, exp);
            err_count++;
        end
    endtask

    ////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////

    // All helpers start and end 2 ns after a rising edge
    task automatic apply_reset();
        rstn   = 1'b0;
        ex_br  = 1'b0;
        ib_pop = 1'b0;
        repeat (8) @(posedge clk);
        #2;
        rstn = 1'b1;
        check_flag(mem_req, 1'b0, "mem_req after reset");
        // BTB valid bits cleared too
        trained.delete();
        model_pc = fetch_pkg::RESET_PC;
    endtask

    task automatic pulse_ex_br(input logic [31:0] from_pc, input logic [31:0] target);
        ex_br        = 1'b1;
        ex_br_pc     = from_pc;
        ex_br_target = target;
        @(posedge clk);
        #2;
        ex_br = 1'b0;
        trained[from_pc] = target;
        model_pc = target;
    endtask

    task automatic wait_for_valid();
        while (!ib_valid) begin
            @(posedge clk);
            #2;
        end
    endtask

    // Pop n entries, each checked against the model
    task automatic consume_entries(input int n, input bit gaps);
        int          got;
        int          r;
        logic        skip;
        logic [31:0] exp_word;
        got = 0;
        while (got < n) begin
            skip = 1'b0;
            if (gaps) begin
                draw_bits(pop_lfsr, 2, r);
                skip = (r == 0);
            end
            if (ib_valid && !skip) begin
                exp_word = mem_word(model_pc);
                check_pc(ib_pc, model_pc, "ib_pc");
                check_instr(ib_instr, exp_word, "ib_instr");
                model_pc = model_next(model_pc);
                got++;
                ib_pop = 1'b1;
            end else begin
                ib_pop = 1'b0;
            end
            @(posedge clk);
            #2;
        end
        ib_pop = 1'b0;
    endtask

    task automatic finish_test(input string name);
        if (err_count == test_err_base) begin
            pass_tests++;
            $display("PASS  %s", name);
        end else begin
            fail_tests++;
            $display("FAIL  %s (%0d errors)", name, err_count - test_err_base);
        end
        test_err_base = err_count;
    endtask

    ////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////

    // Four lines in a row, all misses
    task automatic test_sequential();
        apply_reset();
        consume_entries(16, 1'b0);
        finish_test("sequential fetch across line misses");
    endtask

    // B, BL, B along one path
    task automatic test_direct_jumps();
        apply_reset();
        consume_entries(38, 1'b0);
        finish_test("B and BL redirects");
    endtask

    // Start at 0x7c so the B at 0x9c waits in IF2 while full
    task automatic test_backpressure();
        apply_reset();
        pulse_ex_br(prog_addr('h3f0), prog_addr('h07c));
        wait_for_valid();
        repeat (HOLD_CYCLES) begin
            @(posedge clk);
            #2;
        end
        consume_entries(32, 1'b0);
        finish_test("full buffer back-pressure");
    endtask

    task automatic test_ex_flush();
        apply_reset();
        wait_for_valid();
        check_pc(ib_pc, fetch_pkg::RESET_PC, "ib_pc before flush");
        repeat (10) begin
            @(posedge clk);
            #2;
        end
        pulse_ex_br(prog_addr('h3e4), prog_addr('h100));
        check_flag(ib_valid, 1'b0, "ib_valid after ex_br");
        consume_entries(21, 1'b0);
        finish_test("execute redirect flush");
    endtask

    // 0x14 and 0x20c sit on different BTB indices
    task automatic test_btb_training();
        apply_reset();
        consume_entries(6, 1'b0);
        pulse_ex_br(prog_addr('h014), prog_addr('h200));
        consume_entries(4, 1'b0);
        pulse_ex_br(prog_addr('h20c), prog_addr('h008));
        consume_entries(12, 1'b0);
        finish_test("BTB predicts trained redirect");
    endtask

    task automatic test_random_gaps();
        apply_reset();
        consume_entries(40, 1'b1);
        finish_test("random pop gaps and memory delays");
    endtask

    ////////////////////////////////////////
    // Memory model
    ////////////////////////////////////////

    // LINE_WORDS words per request, 0 to 7 idle cycles before each
    initial begin : memory_model
        int          word;
        int          delay;
        bit          armed;
        logic        req_ok;
        logic [31:0] line_base;
        word      = 0;
        delay     = 0;
        armed     = 1'b0;
        line_base = '0;
        forever begin
            @(posedge clk);
            #1;
            req_ok = rstn && mem_req;
            #1;
            mem_valid = 1'b0;
            if (!req_ok) begin
                word  = 0;
                armed = 1'b0;
            end else begin
                // Fill address line aligned and held for the whole request
                if (word == 0 && !armed) begin
                    line_base = mem_addr & ~32'(4 * fetch_pkg::LINE_WORDS - 1);
                end
                check_pc(mem_addr, line_base, "mem_addr");
                if (!armed) begin
                    draw_bits(mem_lfsr, 3, delay);
                    armed = 1'b1;
                end
                if (delay == 0) begin
                    mem_valid = 1'b1;
                    mem_rdata = mem_word(mem_addr + 32'(4 * word));
                    word++;
                    armed = 1'b0;
                end else begin
                    delay--;
                end
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Timeout: tests still running after %0d ns", WATCHDOG_NS);
        $display("Testbench failed");
        $finish;
    end

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial begin
        rstn          = 1'b0;
        ex_br         = 1'b0;
        ex_br_pc      = '0;
        ex_br_target  = '0;
        ib_pop        = 1'b0;
        mem_valid     = 1'b0;
        mem_rdata     = '0;
        mem_lfsr      = 16'd85;
        pop_lfsr      = 16'd85;
        err_count     = 0;
        test_err_base = 0;
        pass_tests    = 0;
        fail_tests    = 0;
        build_program();

        test_sequential();
        test_direct_jumps();
        test_backpressure();
        test_ex_flush();
        test_btb_training();
        test_random_gaps();

        $display("Tests passed: %0d, failed: %0d", pass_tests, fail_tests);
        if (fail_tests == 0 && err_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* tb/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
    output logic clk
);

    // 40 ns period, first rising edge at 20 ns
    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

endmodule
